/* rtl/mem_subsys_cfg.svh */
`ifndef MEM_SUBSYS_CFG_SVH
`define MEM_SUBSYS_CFG_SVH

////////////////////////////////////////
// Address map
////////////////////////////////////////

// RAM window, decoded as (addr & ~mask) == base
`define MEM_RAM_BASE 32'h4000_0000
`define MEM_RAM_MASK 32'h000F_FFFF

// Two halves of the free-running cycle timer
`define MEM_TIMER_LO 32'h3000_0000
`define MEM_TIMER_HI 32'h3000_0004

////////////////////////////////////////
// Memory
////////////////////////////////////////

// Depth in 32-bit words
`define MEM_RAM_WORDS 1024

// Emulated latency stages for every RAM access
`define MEM_RAM_DELAY 16

////////////////////////////////////////
// Program loader
////////////////////////////////////////

// Clocks per UART bit, short for simulation
`define MEM_CLKS_PER_BIT 16

// Byte that starts program mode
`define MEM_PROG_START 8'hA5

`endif

/* rtl/mem_subsys_pkg.sv */
`include "mem_subsys_cfg.svh"

package mem_subsys_pkg;

  // Word index width of the RAM
  localparam int RAM_AW = $clog2(`MEM_RAM_WORDS);

  ////////////////////////////////////////
  // iomem bus
  ////////////////////////////////////////

  // Request from the bus master, wstrb of zero is a read
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  // Response, rdata only meaningful while ready is high
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } iomem_rsp_t;

  ////////////////////////////////////////
  // RAM access port
  ////////////////////////////////////////

  typedef struct packed {
    logic              rd_en;
    logic [3:0]        wr_strb;
    logic [RAM_AW-1:0] addr;
    logic [31:0]       wdata;
  } ram_port_t;

endpackage

/* rtl/uart_byte_rx.sv */
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module uart_byte_rx (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic       byte_valid_o,
  output logic [7:0] byte_data_o
);

  localparam int CLKS = `MEM_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t state_q;
  logic [1:0]    sync_q;
  logic          rx_s;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_cnt_q;
  logic [7:0]    shift_q;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign rx_s = sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      clk_cnt_q    <= '0;
      bit_cnt_q    <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
          if (!rx_s) begin
            state_q <= ST_START;
          end
        end
        // Wait half a bit, then check the start bit is still low
        ST_START: begin
          if (clk_cnt_q == CW'(CLKS / 2 - 1)) begin
            clk_cnt_q <= '0;
            state_q   <= rx_s ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        // Sample mid-bit, LSB first
        ST_DATA: begin
          if (clk_cnt_q == CW'(CLKS - 1)) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_STOP: begin
          if (clk_cnt_q == CW'(CLKS - 1)) begin
            clk_cnt_q <= '0;
            state_q   <= ST_IDLE;
            // Framing error drops the byte
            byte_valid_o <= rx_s;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data shift register
  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && clk_cnt_q == CW'(CLKS - 1)) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign byte_data_o = shift_q;

endmodule

/* rtl/prog_loader.sv */
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module prog_loader (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  logic                    byte_valid_i,
  input  logic [7:0]              byte_data_i,
  output mem_subsys_pkg::ram_port_t ram_wr_o,
  output logic                    cpu_rst_n_o,
  output logic                    prog_mode_o
);

  import mem_subsys_pkg::*;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_COUNT,
    LD_DATA
  } ld_state_t;

  ld_state_t state_q;
  logic [1:0]        byte_cnt_q;
  logic [31:0]       word_q;
  logic [31:0]       word_next;
  logic [31:0]       words_left_q;
  logic [RAM_AW-1:0] widx_q;
  logic              word_done;

  // Little-endian assembly, first byte ends up in bits 7:0
  assign word_next = {byte_data_i, word_q[31:8]};
  assign word_done = byte_valid_i && (byte_cnt_q == 2'd3);

  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      word_q <= word_next;
    end
  end

  ////////////////////////////////////////
  // Program-mode FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q          <= LD_IDLE;
      byte_cnt_q       <= '0;
      words_left_q     <= '0;
      widx_q           <= '0;
      ram_wr_o.wr_strb <= 4'h0;
    end else begin
      ram_wr_o.wr_strb <= 4'h0;
      case (state_q)
        LD_IDLE: begin
          byte_cnt_q <= '0;
          widx_q     <= '0;
          if (byte_valid_i && byte_data_i == `MEM_PROG_START) begin
            state_q <= LD_COUNT;
          end
        end
        LD_COUNT: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          if (word_done) begin
            words_left_q <= word_next;
            // Empty image
            state_q      <= (word_next == 32'd0) ? LD_IDLE : LD_DATA;
          end
        end
        LD_DATA: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          if (word_done) begin
            ram_wr_o.wr_strb <= 4'hF;
            widx_q           <= widx_q + 1'b1;
            words_left_q     <= words_left_q - 1'b1;
            if (words_left_q == 32'd1) begin
              state_q <= LD_IDLE;
            end
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  // Write payload, latched with the last byte of each word
  always_ff @(posedge clk_i) begin
    if (state_q == LD_DATA && word_done) begin
      ram_wr_o.addr  <= widx_q;
      ram_wr_o.wdata <= word_next;
    end
  end

  // Loader never reads
  assign ram_wr_o.rd_en = 1'b0;

  assign cpu_rst_n_o = (state_q == LD_IDLE);
  assign prog_mode_o = (state_q != LD_IDLE);

endmodule

/* rtl/byte_ram.sv */
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module byte_ram (
  input  logic                      clk_i,
  input  mem_subsys_pkg::ram_port_t bus_port_i,
  input  mem_subsys_pkg::ram_port_t load_port_i,
  output logic [31:0]               rd_data_o
);

  import mem_subsys_pkg::*;

  logic [31:0] mem [`MEM_RAM_WORDS];

  ram_port_t         wr_port;
  logic              rd_en;
  logic [RAM_AW-1:0] rd_addr;

  ////////////////////////////////////////
  // Port selection
  ////////////////////////////////////////

  // Loader writes win over bus writes
  always_comb begin
    if (|load_port_i.wr_strb) begin
      wr_port = load_port_i;
    end else begin
      wr_port = bus_port_i;
    end
  end

  assign rd_en   = load_port_i.rd_en | bus_port_i.rd_en;
  assign rd_addr = load_port_i.rd_en ? load_port_i.addr : bus_port_i.addr;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Four byte lanes
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 4; i++) begin
      if (wr_port.wr_strb[i]) begin
        mem[wr_port.addr][8*i +: 8] <= wr_port.wdata[8*i +: 8];
      end
    end
  end

  // Registered read, holds its value while rd_en is low
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_data_o <= mem[rd_addr];
    end
  end

endmodule

/* rtl/iomem_fabric.sv */
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module iomem_fabric (
  input  logic                       clk_i,
  input  logic                       rst_n,
  input  mem_subsys_pkg::iomem_req_t bus_req_i,
  output mem_subsys_pkg::iomem_rsp_t bus_rsp_o,
  output mem_subsys_pkg::ram_port_t  ram_o,
  input  logic [31:0]                ram_rdata_i
);

  import mem_subsys_pkg::*;

  localparam int DELAY = `MEM_RAM_DELAY;

  logic             ram_sel;
  logic             tlo_sel;
  logic             thi_sel;
  logic             ready;
  logic             ram_done;
  logic             ram_pend_q;
  logic [DELAY-1:0] ram_shift_q;
  logic [63:0]      timer_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign ram_sel = (bus_req_i.addr & ~`MEM_RAM_MASK) == `MEM_RAM_BASE;
  assign tlo_sel = (bus_req_i.addr == `MEM_TIMER_LO);
  assign thi_sel = (bus_req_i.addr == `MEM_TIMER_HI);

  // Non-RAM targets answer in the request cycle
  assign ready    = bus_req_i.valid & (ram_sel ? ram_shift_q[DELAY-1] : 1'b1);
  assign ram_done = ready & ram_sel;

  ////////////////////////////////////////
  // RAM latency emulation
  ////////////////////////////////////////

  // Pending while a RAM request waits for ready
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ram_pend_q <= 1'b0;
    end else begin
      ram_pend_q <= bus_req_i.valid & ram_sel & ~ready;
    end
  end

  // Pending flag walks through the delay line, cleared per transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ram_shift_q <= '0;
    end else if (ram_done) begin
      ram_shift_q <= '0;
    end else begin
      ram_shift_q <= {ram_shift_q[DELAY-2:0], ram_pend_q};
    end
  end

  // Writes land only on the ready edge
  always_comb begin
    ram_o.rd_en   = bus_req_i.valid & ram_sel & ~(|bus_req_i.wstrb);
    ram_o.wr_strb = ram_done ? bus_req_i.wstrb : 4'h0;
    ram_o.addr    = bus_req_i.addr[RAM_AW+1:2];
    ram_o.wdata   = bus_req_i.wdata;
  end

  ////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= 64'h0;
    end else begin
      timer_q <= timer_q + 64'h1;
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_comb begin
    bus_rsp_o.ready = ready;
    if (ram_sel) begin
      bus_rsp_o.rdata = ram_rdata_i;
    end else if (tlo_sel) begin
      bus_rsp_o.rdata = timer_q[31:0];
    end else if (thi_sel) begin
      bus_rsp_o.rdata = timer_q[63:32];
    end else begin
      // Unmapped reads as zero
      bus_rsp_o.rdata = 32'h0;
    end
  end

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic                       clk_i,
  input  logic                       rst_n,
  input  mem_subsys_pkg::iomem_req_t bus_req_i,
  output mem_subsys_pkg::iomem_rsp_t bus_rsp_o,
  input  logic                       prog_rx_i,
  output logic                       cpu_rst_n_o,
  output logic                       prog_mode_o
);

  import mem_subsys_pkg::*;

  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        sys_rst_n;
  ram_port_t   bus_ram;
  ram_port_t   load_ram;
  logic [31:0] ram_rdata;

  // Loader holds the rest of the system in reset while programming
  assign sys_rst_n = cpu_rst_n_o & rst_n;

  uart_byte_rx u_uart_rx (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .rx_i         (prog_rx_i),
    .byte_valid_o (rx_valid),
    .byte_data_o  (rx_data)
  );

  prog_loader u_loader (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .byte_valid_i (rx_valid),
    .byte_data_i  (rx_data),
    .ram_wr_o     (load_ram),
    .cpu_rst_n_o  (cpu_rst_n_o),
    .prog_mode_o  (prog_mode_o)
  );

  iomem_fabric u_fabric (
    .clk_i       (clk_i),
    .rst_n       (sys_rst_n),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .ram_o       (bus_ram),
    .ram_rdata_i (ram_rdata)
  );

  byte_ram u_ram (
    .clk_i       (clk_i),
    .bus_port_i  (bus_ram),
    .load_port_i (load_ram),
    .rd_data_o   (ram_rdata)
  );

endmodule

/* bench/tb_mem_subsys.sv */
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module tb_mem_subsys;

  import mem_subsys_pkg::*;

  localparam int CLKS    = `MEM_CLKS_PER_BIT;
  localparam int DELAY   = `MEM_RAM_DELAY;
  localparam int WORDS   = `MEM_RAM_WORDS;
  localparam int TIMEOUT = 200;
  localparam int N_LOAD  = 4;

  logic       clk_i = 1'b0;
  logic       rst_n;
  iomem_req_t bus_req;
  iomem_rsp_t bus_rsp;
  logic       prog_rx;
  logic       cpu_rst_n;
  logic       prog_mode;
  logic       req_is_ram;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cyc;
  int          rel_cyc;
  int          seed;
  logic [31:0] model [WORDS];

  mem_subsys_top u_dut (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .prog_rx_i   (prog_rx),
    .cpu_rst_n_o (cpu_rst_n),
    .prog_mode_o (prog_mode)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Cycle count from which the timer counts up from zero again
  always @(negedge clk_i) begin
    if (!cpu_rst_n) begin
      rel_cyc <= cyc + 1;
    end
  end

  assign req_is_ram = (bus_req.addr & ~`MEM_RAM_MASK) == `MEM_RAM_BASE;

  ////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////

  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
      bus_rsp.ready |-> bus_req.valid)
    else begin
      $display("** Error at %0t ns: bus_rsp_o.ready expected 0, got 1", $time);
      errors++;
    end

  // A RAM answer lasts a single cycle
  a_ram_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
      (bus_rsp.ready && req_is_ram) |=> !(bus_rsp.ready && req_is_ram))
    else begin
      $display("** Error at %0t ns: bus_rsp_o.ready expected 0, got 1", $time);
      errors++;
    end

  a_mode_vs_reset: assert property (@(posedge clk_i) disable iff (!rst_n)
      prog_mode == !cpu_rst_n)
    else begin
      $display("** Error at %0t ns: prog_mode_o expected %b, got %b", $time,
               !cpu_rst_n, prog_mode);
      errors++;
    end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_eq(input string sig, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, exp, got);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Latency counts cycles from the request cycle to the ready cycle
  task automatic bus_xfer(input logic [31:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int lat, output int at_cyc, input bit chain);
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    bus_req.valid = 1'b1;
    bus_req.addr  = addr;
    bus_req.wstrb = strb;
    bus_req.wdata = wdata;
    @(negedge clk_i);
    while (!bus_rsp.ready && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!bus_rsp.ready) begin
      abort_run("no ready from the bus");
    end
    rdata  = bus_rsp.rdata;
    lat    = n;
    at_cyc = cyc;
    // A chained request follows right after the ready edge with valid kept high
    if (!chain) begin
      @(posedge clk_i);
      #1;
      bus_req.valid = 1'b0;
      bus_req.wstrb = 4'h0;
    end
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output int lat, output int at_cyc);
    bus_xfer(addr, 4'h0, 32'h0, rdata, lat, at_cyc, 1'b0);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] wdata, output int lat);
    logic [31:0] unused;
    int          c;
    bus_xfer(addr, strb, wdata, unused, lat, c, 1'b0);
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge clk_i);
    #1;
    for (int i = 0; i < 10; i++) begin
      prog_rx = frame[i];
      repeat (CLKS) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end
  endtask

  function automatic logic [31:0] ram_addr(input int idx);
    return `MEM_RAM_BASE | (32'(idx) << 2);
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] va;
    logic [31:0] wd;
    logic [3:0]  strb;
    logic [31:0] load [N_LOAD];
    int          lat;
    int          ca;
    int          cb;
    int          e0;
    int          n;
    int          idx [8];
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc          = 0;
    rel_cyc      = 0;
    seed         = 32'h669c_a5d7;
    rst_n        = 1'b0;
    prog_rx      = 1'b1;
    bus_req      = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    e0 = errors;
    @(negedge clk_i);
    check_eq("bus_rsp_o.ready", 32'd0, 32'(bus_rsp.ready));
    check_eq("prog_mode_o", 32'd0, 32'(prog_mode));
    check_eq("cpu_rst_n_o", 32'd1, 32'(cpu_rst_n));
    end_test("reset", e0);

    // Back-to-back reads, so each new request starts its latency afresh
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      bus_xfer(ram_addr($random(seed) & (WORDS - 1)), 4'h0, 32'h0, rd, lat, ca, i < 5);
      check_eq("ram latency", 32'(DELAY + 1), 32'(lat));
    end
    end_test("ram latency", e0);

    // Full writes, partial writes, then read back
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      idx[i] = (i * 37 + ($random(seed) & 15)) & (WORDS - 1);
      wd     = $random(seed);
      bus_write(ram_addr(idx[i]), 4'hF, wd, lat);
      model[idx[i]] = wd;
    end
    for (int i = 0; i < 8; i++) begin
      wd   = $random(seed);
      strb = 4'($random(seed));
      if (strb == 4'h0) begin
        strb = 4'h5;
      end
      bus_write(ram_addr(idx[i]), strb, wd, lat);
      model[idx[i]] = merge_bytes(model[idx[i]], wd, strb);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr(idx[i]), rd, lat, ca);
      check_eq("bus_rsp_o.rdata", model[idx[i]], rd);
    end
    end_test("byte strobes", e0);

    e0 = errors;
    bus_read(`MEM_TIMER_HI, rd, lat, ca);
    check_eq("timer hi latency", 32'd0, 32'(lat));
    check_eq("timer hi", 32'd0, rd);
    bus_read(`MEM_TIMER_LO, va, lat, ca);
    check_eq("timer lo latency", 32'd0, 32'(lat));
    repeat (13) @(posedge clk_i);
    bus_read(`MEM_TIMER_LO, rd, lat, cb);
    check_eq("timer lo delta", 32'(cb - ca), rd - va);
    bus_read(32'h2000_0010, rd, lat, ca);
    check_eq("unmapped latency", 32'd0, 32'(lat));
    check_eq("unmapped rdata", 32'd0, rd);
    end_test("timer", e0);

    // Program load over the UART line
    e0 = errors;
    uart_send(8'h12);
    uart_send(8'h5A);
    check_eq("prog_mode_o", 32'd0, 32'(prog_mode));
    uart_send(`MEM_PROG_START);
    check_eq("prog_mode_o", 32'd1, 32'(prog_mode));
    check_eq("cpu_rst_n_o", 32'd0, 32'(cpu_rst_n));
    for (int b = 0; b < 4; b++) begin
      uart_send(8'(N_LOAD >> (8 * b)));
    end
    for (int w = 0; w < N_LOAD; w++) begin
      load[w] = $random(seed);
      for (int b = 0; b < 4; b++) begin
        if (w == N_LOAD - 1 && b == 3) begin
          check_eq("prog_mode_o", 32'd1, 32'(prog_mode));
          check_eq("cpu_rst_n_o", 32'd0, 32'(cpu_rst_n));
        end
        uart_send(load[w][8*b +: 8]);
      end
    end
    n = 0;
    while (!cpu_rst_n && n < TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!cpu_rst_n) begin
      abort_run("processor reset never released");
    end
    // Timer counts the cycles since the processor reset was released
    bus_read(`MEM_TIMER_LO, rd, lat, cb);
    check_eq("timer lo after release", 32'(cb - rel_cyc), rd);
    for (int w = 0; w < N_LOAD; w++) begin
      bus_read(ram_addr(w), rd, lat, ca);
      check_eq("loaded word", load[w], rd);
    end
    end_test("program load", e0);

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* mem_subsys_top.f */
+incdir+rtl
rtl/mem_subsys_pkg.sv
rtl/uart_byte_rx.sv
rtl/prog_loader.sv
rtl/byte_ram.sv
rtl/iomem_fabric.sv
rtl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

/* Makefile */
SIM = obj_dir/Vtb_mem_subsys

.PHONY: all run lint clean

all: run

$(SIM): mem_subsys_top.f rtl/*.sv rtl/*.svh bench/*.sv
	verilator --binary --timing --assert -f mem_subsys_top.f \
		--top-module tb_mem_subsys -o Vtb_mem_subsys

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing -Wall -Irtl \
		rtl/mem_subsys_pkg.sv rtl/uart_byte_rx.sv rtl/prog_loader.sv \
		rtl/byte_ram.sv rtl/iomem_fabric.sv rtl/mem_subsys_top.sv \
		--top-module mem_subsys_top

clean:
	rm -rf obj_dir
